/* mbus_input.txt */
# address(hex) data(hex) corrupt_bit ack_delay outcome
# corrupt_bit is the frame bit to invert, 0 start .. 42 stop, -1 for none
a5 12345678 -1 0 DELIVER
3c deadbeef -1 2 DELIVER
f1 00000000 -1 1 DELIVER
10 ffffffff -1 0 DELIVER
07 cafe0001 -1 1 DELIVER
0f 5a5a5a5a -1 3 DELIVER
00 00000003 -1 0 ABSORB
81 00000001 -1 2 DELIVER
00 12340001 -1 0 ABSORB
42 87654321 3 0 FAIL
42 87654321 20 0 FAIL
42 87654321 41 0 FAIL
00 00000002 1 0 FAIL
0c 13579bdf 40 0 FAIL
9e 0badf00d -1 2 OVERRUN
00 00000002 -1 0 ABSORB
05 a5a5a5a5 -1 1 OVERRUN
66 00c0ffee -1 0 DELIVER
00 00000000 -1 0 ABSORB

/* files.f */
mbus_pkg.sv
mbus_bit_timer.sv
mbus_tx_framer.sv
mbus_rx_deframer.sv
mbus_ctrl_filter.sv
mbus_layer.sv
mbus_checker.sv
tb_mbus_layer.sv

/* tb_mbus_layer.sv */
/*
 * mbus layer testbench.
 * reads test vectors, drives the host ports, loops dout back
 * to din with optional bit corruption and acks received messages.
 */

`default_nettype none

module tb_mbus_layer;

	localparam int BIT_CYCLES = 4;
	// long enough for three back to back frames.
	localparam int TIMEOUT = 1000 * BIT_CYCLES;

	logic                CLK_EXT = 1'b0;
	logic                RESETn_local;
	logic                din;
	logic                tx_req;
	logic                rx_ack;
	mbus_pkg::mbus_msg_t tx_msg;
	logic                dout;
	logic                clkout;
	logic                tx_ack;
	logic                rx_req;
	logic                rx_broadcast;
	logic                rx_fail;
	mbus_pkg::mbus_msg_t rx_msg;
	logic [1:0]          ctrl_bits;
	int                  rises = 0;
	int                  rise_base = 0;
	int                  corrupt_idx;
	int                  bad_lines = 0;

	mbus_layer #(
		.BIT_CYCLES(BIT_CYCLES)
	) dut_i (
		.CLK_EXT(CLK_EXT), .RESETn_local(RESETn_local), .din(din),
		.tx_req(tx_req), .rx_ack(rx_ack), .tx_msg(tx_msg), .dout(dout),
		.clkout(clkout), .tx_ack(tx_ack), .rx_req(rx_req),
		.rx_broadcast(rx_broadcast), .rx_fail(rx_fail), .rx_msg(rx_msg),
		.ctrl_bits(ctrl_bits)
	);

	mbus_checker #(
		.BIT_CYCLES(BIT_CYCLES)
	) chk_i (
		.CLK_EXT(CLK_EXT), .RESETn_local(RESETn_local), .clkout(clkout),
		.dout(dout), .tx_ack(tx_ack), .rx_req(rx_req),
		.rx_broadcast(rx_broadcast), .rx_fail(rx_fail), .rx_msg(rx_msg),
		.ctrl_bits(ctrl_bits)
	);

	always #2 CLK_EXT = ~CLK_EXT;

	always @(posedge clkout)
		rises = rises + 1;

	// ring loopback, one frame bit inverted while its clock pulse is high.
	assign din = dout ^ ((corrupt_idx >= 0) && clkout &&
		(rises - rise_base - 1 == corrupt_idx));

	task automatic stall(input string what);
		$display("timeout while waiting for %s", what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic wait_tx_ack(input logic level);
		int n;
		n = 0;
		@(negedge CLK_EXT);
		while (tx_ack !== level)
		begin
			if (n >= TIMEOUT)
				stall(level ? "tx_ack to rise" : "tx_ack to fall");
			n++;
			@(negedge CLK_EXT);
		end
	endtask

	task automatic wait_rx_req(input logic level);
		int n;
		n = 0;
		@(negedge CLK_EXT);
		while (rx_req !== level)
		begin
			if (n >= TIMEOUT)
				stall(level ? "rx_req to rise" : "rx_req to fall");
			n++;
			@(negedge CLK_EXT);
		end
	endtask

	task automatic wait_pulses(input int count);
		int n;
		n = 0;
		@(negedge CLK_EXT);
		while (rises - rise_base < count)
		begin
			if (n >= TIMEOUT)
				stall($sformatf("%0d clkout pulses", count));
			n++;
			@(negedge CLK_EXT);
		end
	endtask

	task automatic send_msg(input mbus_pkg::mbus_msg_t m);
		@(posedge CLK_EXT);
		tx_msg <= m;
		tx_req <= 1'b1;
		wait_tx_ack(1'b1);
		@(posedge CLK_EXT);
		tx_req <= 1'b0;
		wait_tx_ack(1'b0);
	endtask

	task automatic host_receive(input int delay);
		wait_rx_req(1'b1);
		repeat (delay + ($urandom % 3))
			@(posedge CLK_EXT);
		@(posedge CLK_EXT);
		rx_ack <= 1'b1;
		wait_rx_req(1'b0);
		@(posedge CLK_EXT);
		rx_ack <= 1'b0;
	endtask

	task automatic run_test(input int num, input mbus_pkg::mbus_msg_t m, input int cidx,
		input int delay, input logic [63:0] word);
		logic bcast;
		bcast = (m.addr[7:4] == mbus_pkg::BCAST_PREFIX);
		@(posedge CLK_EXT);
		rise_base = rises;
		if (word == "DELIVER")
		begin
			chk_i.start_test(num, "deliver", 0, 43);
			chk_i.expect_msg(bcast, m);
			send_msg(m);
			host_receive(delay);
			wait_pulses(43);
		end
		else if (word == "ABSORB" || word == "FAIL")
		begin
			chk_i.start_test(num, word == "FAIL" ? "fail" : "absorb",
				word == "FAIL" ? 1 : 0, 43);
			if (word == "ABSORB")
				chk_i.set_ctrl(m.data[1:0]);
			corrupt_idx <= cidx;
			send_msg(m);
			wait_pulses(43);
			repeat (4 * BIT_CYCLES)
				@(posedge CLK_EXT);
			corrupt_idx <= -1;
		end
		else if (word == "OVERRUN")
		begin
			// second frame waits in the deframer, third is dropped.
			chk_i.start_test(num, "overrun", 1, 129);
			chk_i.expect_msg(bcast, m);
			chk_i.expect_msg(bcast, {m.addr, ~m.data});
			send_msg(m);
			send_msg({m.addr, ~m.data});
			send_msg({m.addr, m.data ^ 32'h0000ffff});
			wait_pulses(129);
			repeat (4 * BIT_CYCLES)
				@(posedge CLK_EXT);
			host_receive(delay);
			host_receive(delay);
		end
		else
		begin
			$display("unknown outcome in test %0d of the data file", num);
			bad_lines++;
			return;
		end
		chk_i.finish_test();
	endtask

	initial
	begin : main
		int fd;
		int cnt;
		int num;
		int cidx;
		int delay;
		int unsigned seed;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [63:0] word;
		string line;
		seed = 32'h86c3;
		void'($urandom(seed));
		RESETn_local = 1'b0;
		tx_req = 1'b0;
		rx_ack = 1'b0;
		tx_msg = '0;
		corrupt_idx = -1;
		num = 0;
		repeat (8)
			@(posedge CLK_EXT);
		RESETn_local <= 1'b1;
		@(negedge CLK_EXT);
		chk_i.check_reset_values();
		fd = $fopen("mbus_input.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file mbus_input.txt");
			bad_lines++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				cnt = $fgets(line, fd);
				cnt = $sscanf(line, "%h %h %d %d %s", addr, data, cidx, delay, word);
				if (cnt == 5)
				begin
					num++;
					run_test(num, {addr, data}, cidx, delay, word);
				end
			end
			$fclose(fd);
		end
		chk_i.report();
		if (chk_i.err_count == 0 && bad_lines == 0 && num > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* mbus_checker.sv */
/*
 * mbus testbench checker.
 * watches the DUT ports, compares deliveries, fail pulses,
 * bus clock pulses and control bits, and prints one line per test.
 */

`default_nettype none

module mbus_checker #(
	parameter int BIT_CYCLES = 4
) (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	input  logic                clkout,
	input  logic                dout,
	input  logic                tx_ack,
	input  logic                rx_req,
	input  logic                rx_broadcast,
	input  logic                rx_fail,
	input  mbus_pkg::mbus_msg_t rx_msg,
	input  logic [1:0]          ctrl_bits
);

	// each entry is broadcast flag then message.
	logic [40:0] exp_q[$];
	logic [1:0]  exp_ctrl = 2'b00;
	logic        clkout_q = 1'b0;
	logic        rx_req_q = 1'b0;
	int          err_count = 0;
	int          test_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_num = 0;
	string       test_name = "";
	int          exp_fails = 0;
	int          exp_pulses = 0;
	int          fails_seen = 0;
	int          pulses_seen = 0;
	int          high_cnt = 0;

	task automatic error(input string msg);
		$display("FAILED at %0t: test %0d %s", $time, test_num, msg);
		err_count++;
		test_errs++;
	endtask

	task automatic expect_msg(input logic bcast, input mbus_pkg::mbus_msg_t m);
		exp_q.push_back({bcast, m});
	endtask

	task automatic set_ctrl(input logic [1:0] bits);
		exp_ctrl = bits;
	endtask

	task automatic start_test(input int num, input string name, input int fails,
		input int pulses);
		test_num    = num;
		test_name   = name;
		exp_fails   = fails;
		exp_pulses  = pulses;
		fails_seen  = 0;
		pulses_seen = 0;
		test_errs   = 0;
	endtask

	task automatic check_reset_values();
		start_test(0, "reset", 0, 0);
		if (dout !== 1'b1)
			error("dout not high after reset");
		if (clkout !== 1'b0)
			error("clkout not low after reset");
		if ({tx_ack, rx_req, rx_fail, rx_broadcast} !== 4'b0000)
			error("handshake or status output not low after reset");
		if (ctrl_bits !== 2'b00)
			error("ctrl_bits not zero after reset");
		finish_test();
	endtask

	task automatic finish_test();
		if (exp_q.size() != 0)
			error($sformatf("%0d expected messages never delivered", exp_q.size()));
		exp_q.delete();
		if (fails_seen != exp_fails)
			error($sformatf("rx_fail pulses %0d expected %0d", fails_seen, exp_fails));
		if (pulses_seen != exp_pulses)
			error($sformatf("clkout pulses %0d expected %0d", pulses_seen, exp_pulses));
		if (ctrl_bits !== exp_ctrl)
			error($sformatf("ctrl_bits %b expected %b", ctrl_bits, exp_ctrl));
		tests_run++;
		if (test_errs == 0)
			$display("test %0d %s: passed", test_num, test_name);
		else
		begin
			$display("test %0d %s: failed, %0d errors", test_num, test_name, test_errs);
			tests_failed++;
		end
	endtask

	task automatic report();
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, err_count);
	endtask

	// sampled mid-cycle, away from the DUT's clock edge.
	always @(negedge CLK_EXT)
	begin : sample
		logic [40:0] e;
		if (RESETn_local)
		begin
			if (clkout && !clkout_q)
				pulses_seen++;
			if (clkout)
				high_cnt++;
			else if (clkout_q)
			begin
				if (high_cnt != BIT_CYCLES / 2)
					error($sformatf("clkout high for %0d cycles", high_cnt));
				high_cnt = 0;
			end
			if (rx_fail)
				fails_seen++;
			if (rx_req && !rx_req_q)
			begin
				if (exp_q.size() == 0)
					error($sformatf("unexpected rx_req with addr %h", rx_msg.addr));
				else
				begin
					e = exp_q.pop_front();
					if (rx_msg !== e[39:0])
						error($sformatf("rx_msg %h expected %h", rx_msg, e[39:0]));
					if (rx_broadcast !== e[40])
						error($sformatf("rx_broadcast %b expected %b", rx_broadcast, e[40]));
				end
			end
		end
		clkout_q = clkout;
		rx_req_q = rx_req;
	end

endmodule

`default_nettype wire

/* mbus_layer.sv */
/*
 * mbus layer top, master mode.
 * framer to bus, bus to deframer, deframer to control filter,
 * all timed by one bit timer on CLK_EXT.
 */

`default_nettype none

module mbus_layer #(
	parameter int BIT_CYCLES = 4
) (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	input  logic                din,
	input  logic                tx_req,
	input  logic                rx_ack,
	input  mbus_pkg::mbus_msg_t tx_msg,
	output logic                dout,
	output logic                clkout,
	output logic                tx_ack,
	output logic                rx_req,
	output logic                rx_broadcast,
	output logic                rx_fail,
	output mbus_pkg::mbus_msg_t rx_msg,
	output logic [1:0]          ctrl_bits
);

	logic                bit_start;
	logic                bit_mid;
	logic                run;
	logic                frame_req;
	logic                frame_ack;
	mbus_pkg::mbus_msg_t rx_frame;

	mbus_bit_timer #(
		.BIT_CYCLES(BIT_CYCLES)
	) timer_i (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.run(run),
		.bit_start(bit_start),
		.bit_mid(bit_mid),
		.clkout(clkout)
	);

	mbus_tx_framer framer_i (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.tx_req(tx_req),
		.bit_start(bit_start),
		.tx_msg(tx_msg),
		.tx_ack(tx_ack),
		.dout(dout),
		.run(run),
		.tx_done()
	);

	mbus_rx_deframer deframer_i (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.din(din),
		.bit_mid(bit_mid),
		.frame_ack(frame_ack),
		.frame_req(frame_req),
		.rx_fail(rx_fail),
		.rx_frame(rx_frame)
	);

	mbus_ctrl_filter filter_i (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.frame_req(frame_req),
		.rx_ack(rx_ack),
		.rx_frame(rx_frame),
		.frame_ack(frame_ack),
		.rx_req(rx_req),
		.rx_broadcast(rx_broadcast),
		.rx_msg(rx_msg),
		.ctrl_bits(ctrl_bits)
	);

endmodule

`default_nettype wire

/* mbus_ctrl_filter.sv */
/*
 * mbus control channel filter.
 * holds one received message, absorbs control broadcasts and
 * keeps their control bits, forwards the rest to the host.
 */

`default_nettype none

module mbus_ctrl_filter (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	input  logic                frame_req,
	input  logic                rx_ack,
	input  mbus_pkg::mbus_msg_t rx_frame,
	output logic                frame_ack,
	output logic                rx_req,
	output logic                rx_broadcast,
	output mbus_pkg::mbus_msg_t rx_msg,
	output logic [1:0]          ctrl_bits
);

	mbus_pkg::prefix_t held_prefix;
	mbus_pkg::func_t   held_func;
	logic              full;
	logic              host_done;
	logic              accept;
	logic              is_ctrl;

	assign {held_prefix, held_func} = rx_msg.addr;

	assign is_ctrl = (held_prefix == mbus_pkg::BCAST_PREFIX) &&
		(held_func == mbus_pkg::CTRL_FUNC);

	// no accept while the holding register is in use.
	assign accept = frame_req && !frame_ack && !full;

	always_ff @(posedge CLK_EXT)
	begin
		if (accept)
			rx_msg <= rx_frame;
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			frame_ack    <= 1'b0;
			full         <= 1'b0;
			host_done    <= 1'b0;
			rx_req       <= 1'b0;
			rx_broadcast <= 1'b0;
			ctrl_bits    <= 2'b00;
		end
		else
		begin
			if (accept)
			begin
				frame_ack <= 1'b1;
				full      <= 1'b1;
			end
			else if (frame_ack && !frame_req)
				frame_ack <= 1'b0;

			if (full)
			begin
				if (is_ctrl)
				begin
					ctrl_bits <= rx_msg.data[1:0];
					full      <= 1'b0;
				end
				else if (host_done)
				begin
					// host dropped ack, handshake closed.
					if (!rx_ack)
					begin
						host_done <= 1'b0;
						full      <= 1'b0;
					end
				end
				else if (rx_req)
				begin
					if (rx_ack)
					begin
						rx_req    <= 1'b0;
						host_done <= 1'b1;
					end
				end
				else
				begin
					rx_req       <= 1'b1;
					rx_broadcast <= (held_prefix == mbus_pkg::BCAST_PREFIX);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* mbus_rx_deframer.sv */
/*
 * mbus receive deframer.
 * samples din at mid-bit, rebuilds the frame, checks parity and
 * stop bit and offers good messages by four-phase req/ack.
 */

`default_nettype none

module mbus_rx_deframer (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	input  logic                din,
	input  logic                bit_mid,
	input  logic                frame_ack,
	output logic                frame_req,
	output logic                rx_fail,
	output mbus_pkg::mbus_msg_t rx_frame
);

	// bits that follow the start bit.
	localparam int BODY_BITS = mbus_pkg::FRAME_BITS - 1;
	localparam mbus_pkg::bit_cnt_t LAST_BIT = mbus_pkg::FRAME_BITS - 6'd2;

	mbus_pkg::rx_state_t  state;
	mbus_pkg::bit_cnt_t   bit_cnt;
	logic [BODY_BITS-1:0] shreg;
	logic                 frame_ok;
	logic                 out_free;
	logic                 deliver;

	// address, data and parity give even weight, stop is high.
	assign frame_ok = !(^shreg[BODY_BITS-1:1]) && shreg[0];

	// previous handshake fully closed.
	assign out_free = !frame_req && !frame_ack;

	assign deliver = (state == mbus_pkg::RX_CHECK) && frame_ok && out_free;

	always_ff @(posedge CLK_EXT)
	begin
		if ((state == mbus_pkg::RX_SHIFT) && bit_mid)
			shreg <= {shreg[BODY_BITS-2:0], din};
		if (deliver)
			rx_frame <= shreg[BODY_BITS-1:2];
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state     <= mbus_pkg::RX_HUNT;
			bit_cnt   <= '0;
			frame_req <= 1'b0;
			rx_fail   <= 1'b0;
		end
		else
		begin
			rx_fail <= 1'b0;
			if (deliver)
				frame_req <= 1'b1;
			else if (frame_req && frame_ack)
				frame_req <= 1'b0;

			case (state)
				mbus_pkg::RX_HUNT:
				begin
					if (bit_mid && !din)
					begin
						state   <= mbus_pkg::RX_SHIFT;
						bit_cnt <= '0;
					end
				end
				mbus_pkg::RX_SHIFT:
				begin
					if (bit_mid)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_BIT)
							state <= mbus_pkg::RX_CHECK;
					end
				end
				mbus_pkg::RX_CHECK:
				begin
					// bad frame or overrun, frame dropped.
					if (!deliver)
						rx_fail <= 1'b1;
					state <= mbus_pkg::RX_HUNT;
				end
				default:
					state <= mbus_pkg::RX_HUNT;
			endcase
		end
	end

endmodule

`default_nettype wire

/* mbus_tx_framer.sv */
/*
 * mbus transmit framer.
 * takes one host message by four-phase req/ack, adds start,
 * parity and stop bits and shifts the frame out MSB first.
 */

`default_nettype none

module mbus_tx_framer (
	input  logic                CLK_EXT,
	input  logic                RESETn_local,
	input  logic                tx_req,
	input  logic                bit_start,
	input  mbus_pkg::mbus_msg_t tx_msg,
	output logic                tx_ack,
	output logic                dout,
	output logic                run,
	output logic                tx_done
);

	mbus_pkg::tx_state_t state;
	mbus_pkg::bit_cnt_t  bit_cnt;
	logic                loaded;
	logic                parity;
	logic                accept;
	logic                shift_en;
	logic [mbus_pkg::FRAME_BITS-1:0] frame_q;

	// even parity over address and data.
	assign parity = ^{tx_msg.addr, tx_msg.data};

	assign accept = (state == mbus_pkg::TX_IDLE) && !loaded && tx_req && !tx_ack;

	// first bit leaves from idle, the rest from shift.
	assign shift_en = bit_start &&
		(((state == mbus_pkg::TX_IDLE) && loaded) ||
		((state == mbus_pkg::TX_SHIFT) && (bit_cnt != mbus_pkg::FRAME_BITS)));

	always_ff @(posedge CLK_EXT)
	begin
		if (accept)
			frame_q <= {1'b0, tx_msg.addr, tx_msg.data, parity, 1'b1};
		else if (shift_en)
			frame_q <= {frame_q[mbus_pkg::FRAME_BITS-2:0], 1'b1};
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state   <= mbus_pkg::TX_IDLE;
			bit_cnt <= '0;
			loaded  <= 1'b0;
			tx_ack  <= 1'b0;
			dout    <= 1'b1;
			run     <= 1'b0;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (accept)
			begin
				tx_ack <= 1'b1;
				loaded <= 1'b1;
			end
			else if (tx_ack && !tx_req)
				tx_ack <= 1'b0;

			if (shift_en)
			begin
				dout    <= frame_q[mbus_pkg::FRAME_BITS-1];
				bit_cnt <= bit_cnt + 1'b1;
			end

			case (state)
				mbus_pkg::TX_IDLE:
				begin
					if (loaded && bit_start)
					begin
						state   <= mbus_pkg::TX_SHIFT;
						loaded  <= 1'b0;
						run     <= 1'b1;
						bit_cnt <= 6'd1;
					end
				end
				mbus_pkg::TX_SHIFT:
				begin
					// stop bit period has ended.
					if (bit_start && (bit_cnt == mbus_pkg::FRAME_BITS))
					begin
						state   <= mbus_pkg::TX_DONE;
						dout    <= 1'b1;
						run     <= 1'b0;
						tx_done <= 1'b1;
					end
				end
				default:
					state <= mbus_pkg::TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* mbus_bit_timer.sv */
/*
 * mbus bit timer.
 * divides CLK_EXT into bit periods, gives start and mid-bit
 * strobes and drives the bus clock while a frame is sent.
 */

`default_nettype none

module mbus_bit_timer #(
	parameter int BIT_CYCLES = 4
) (
	input  logic CLK_EXT,
	input  logic RESETn_local,
	input  logic run,
	output logic bit_start,
	output logic bit_mid,
	output logic clkout
);

	localparam int CNT_W = $clog2(BIT_CYCLES);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(BIT_CYCLES - 1);
	localparam logic [CNT_W-1:0] HALF = CNT_W'(BIT_CYCLES / 2);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;

	// free running so the receiver can hunt while idle.
	assign cnt_next = (cnt == LAST) ? '0 : cnt + 1'b1;

	assign bit_start = (cnt == '0);
	assign bit_mid   = (cnt == HALF);

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			cnt    <= '0;
			clkout <= 1'b0;
		end
		else
		begin
			cnt <= cnt_next;
			// high in the second half of the period.
			clkout <= run && (cnt_next >= HALF);
		end
	end

endmodule

`default_nettype wire

/* mbus_pkg.sv */
/*
 * mbus shared definitions.
 * message types, address fields, frame constants and the
 * state encodings of the framer and deframer.
 */

`default_nettype none

package mbus_pkg;

	// address is prefix in the high nibble, function id in the low nibble.
	typedef logic [7:0]  addr_t;
	typedef logic [3:0]  prefix_t;
	typedef logic [3:0]  func_t;
	typedef logic [31:0] data_t;

	// counts bits within one frame.
	typedef logic [5:0]  bit_cnt_t;

	typedef struct packed {
		addr_t addr;
		data_t data;
	} mbus_msg_t;

	// prefix zero addresses every node.
	localparam prefix_t BCAST_PREFIX = 4'h0;

	// control channel on broadcast.
	localparam func_t CTRL_FUNC = 4'h0;

	// start, 8 address, 32 data, parity, stop.
	localparam bit_cnt_t FRAME_BITS = 6'd43;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_SHIFT,
		TX_DONE
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_HUNT,
		RX_SHIFT,
		RX_CHECK
	} rx_state_t;

endpackage

`default_nettype wire
